/* bench/tb_spm_model.svh */
`ifndef TB_SPM_MODEL_SVH
`define TB_SPM_MODEL_SVH

// ----------------------------------------
// Random numbers
// ----------------------------------------
logic [31:0] rand_state = 32'h1f22bf23;

function automatic logic [31:0] next_rand();
  rand_state = rand_state * 32'd1664525 + 32'd1013904223;
  return rand_state;
endfunction

// ----------------------------------------
// Region map and memory model
// ----------------------------------------
// Written data and written byte lanes, keyed by word address
wb_data_t model_mem [wb_addr_t];
wb_sel_t  model_written [wb_addr_t];

// Region index of an address, -1 in a gap
function automatic int map_region(wb_addr_t addr);
  logic [AddrWidth:0] lo;
  logic [AddrWidth:0] hi;
  int                 found;
  found = -1;
  for (int i = 0; i < NumRegions; i++) begin
    lo = RegionBase + i * RegionStride;
    hi = lo + RegionBytes;
    if ((addr >= lo) && (addr < hi)) begin
      found = i;
    end
  end
  return found;
endfunction

task automatic model_write(wb_addr_t addr, wb_data_t data, wb_sel_t sel);
  wb_addr_t key;
  key = addr & ~wb_addr_t'(SelWidth - 1);
  if (!model_mem.exists(key)) begin
    model_mem[key]     = '0;
    model_written[key] = '0;
  end
  for (int b = 0; b < SelWidth; b++) begin
    if (sel[b]) begin
      model_mem[key][8*b +: 8] = data[8*b +: 8];
      model_written[key][b]    = 1'b1;
    end
  end
endtask

// Expected word and a bit mask of the bytes that were ever written
task automatic model_read(input wb_addr_t addr, output wb_data_t data, output wb_data_t bits);
  wb_addr_t key;
  key  = addr & ~wb_addr_t'(SelWidth - 1);
  data = '0;
  bits = '0;
  if (model_mem.exists(key)) begin
    data = model_mem[key];
    for (int b = 0; b < SelWidth; b++) begin
      bits[8*b +: 8] = {8{model_written[key][b]}};
    end
  end
endtask

// ----------------------------------------
// Compare tasks
// ----------------------------------------
task automatic check_data(string name, wb_data_t exp, wb_data_t act);
  if (act !== exp) begin
    abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
  end
endtask

task automatic check_resp(string name, logic exp_ack, logic exp_err,
                          logic act_ack, logic act_err);
  if ((act_ack !== exp_ack) || (act_err !== exp_err)) begin
    abort_run($sformatf("[FAIL] %s: expected ack=%b err=%b, actual ack=%b err=%b",
                        name, exp_ack, exp_err, act_ack, act_err));
  end
endtask

task automatic check_latency(string name, int exp, int act);
  if (act != exp) begin
    abort_run($sformatf("[FAIL] %s: expected latency %0d, actual %0d", name, exp, act));
  end
endtask

`endif

/* bench/tb_spm_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_spm_subsystem;
  import spm_pkg::*;

  localparam int ClkPeriod   = 10;
  localparam int ResetCycles = 8;
  localparam int NumDirected = 21;
  localparam int NumRandom   = 2000;
  // 20 cycles per access plus reset
  localparam int TimeoutNs   = (ResetCycles + 20 * (NumDirected + NumRandom)) * ClkPeriod;

  logic     clk;
  logic     ndmreset_n;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_addr_t wb_adr;
  wb_data_t wb_dat_w;
  wb_sel_t  wb_sel;
  wb_data_t wb_dat_r;
  logic     wb_ack;
  logic     wb_err;

  task automatic abort_run(string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  `include "tb_spm_model.svh"

  spm_subsystem dut (
    .clk_i      ( clk        ),
    .ndmreset_n ( ndmreset_n ),
    .wb_cyc_i   ( wb_cyc     ),
    .wb_stb_i   ( wb_stb     ),
    .wb_we_i    ( wb_we      ),
    .wb_adr_i   ( wb_adr     ),
    .wb_dat_i   ( wb_dat_w   ),
    .wb_sel_i   ( wb_sel     ),
    .wb_dat_o   ( wb_dat_r   ),
    .wb_ack_o   ( wb_ack     ),
    .wb_err_o   ( wb_err     )
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // ----------------------------------------
  // Bus access
  // ----------------------------------------
  // Called 1 ns after a rising edge, returns at the same point
  task automatic bus_access(string name, logic we, wb_addr_t adr, wb_data_t dat, wb_sel_t sel);
    int       region;
    int       cycles;
    wb_data_t exp_data;
    wb_data_t exp_bits;
    region = map_region(adr);
    model_read(adr, exp_data, exp_bits);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    wb_sel   = sel;
    cycles   = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while ((wb_ack !== 1'b1) && (wb_err !== 1'b1));
    check_latency(name, 1, cycles);
    check_resp(name, region >= 0, region < 0, wb_ack, wb_err);
    if ((region >= 0) && !we) begin
      check_data(name, exp_data & exp_bits, wb_dat_r & exp_bits);
    end
    if ((region >= 0) && we) begin
      model_write(adr, dat, sel);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    // Response must be a single cycle
    @(posedge clk);
    #1;
    check_resp({name, " idle"}, 1'b0, 1'b0, wb_ack, wb_err);
  endtask

  // Half inside regions near either end, half in the gaps
  function automatic wb_addr_t rand_addr();
    logic [31:0] r;
    wb_addr_t    base;
    int unsigned word;
    r    = next_rand();
    base = RegionBase + r[31:30] * RegionStride;
    word = r[27:23];
    if (r[29]) begin
      if (r[28]) begin
        word = BankWords - 1 - word;
      end
      return base + word * SelWidth;
    end
    case (r[22:21] % 3)
      0:       return RegionBase - SelWidth * (1 + r[20:15]);
      1:       return base + RegionBytes + SelWidth * r[20:15];
      default: return base + RegionBytes + ((r[20:5] % (RegionStride - RegionBytes)) & ~32'd3);
    endcase
  endfunction

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    wb_addr_t    adr;
    logic [31:0] r;
    clk        = 1'b0;
    ndmreset_n = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    wb_sel     = '0;

    // Reset state
    repeat (ResetCycles) begin
      @(posedge clk);
      #1;
      check_resp("reset", 1'b0, 1'b0, wb_ack, wb_err);
    end
    ndmreset_n = 1'b1;
    @(posedge clk);
    #1;
    check_resp("after reset", 1'b0, 1'b0, wb_ack, wb_err);

    // Each region keeps its own word at the same offset
    for (int i = 0; i < NumRegions; i++) begin
      bus_access("region write", 1'b1, RegionBase + i * RegionStride + 32'h40,
                 32'h5eed_0000 + i * 32'h0101, 4'hf);
    end
    for (int i = 0; i < NumRegions; i++) begin
      bus_access("region read", 1'b0, RegionBase + i * RegionStride + 32'h40, '0, 4'hf);
    end

    // Partial writes merge with earlier bytes
    adr = RegionBase + 2 * RegionStride + 32'h80;
    bus_access("byte write full", 1'b1, adr, 32'h1122_3344, 4'hf);
    bus_access("byte write 0101", 1'b1, adr, 32'haabb_ccdd, 4'b0101);
    bus_access("byte write 1000", 1'b1, adr, 32'hee00_0000, 4'b1000);
    bus_access("byte read", 1'b0, adr, '0, 4'hf);

    // Gaps, below region 0 and above the last region
    bus_access("below region 0", 1'b1, RegionBase - 32'h4, 32'hdead_0001, 4'hf);
    bus_access("gap after 1", 1'b1, RegionBase + RegionStride + RegionBytes, 32'hdead_0002, 4'hf);
    bus_access("gap alias", 1'b1, RegionBase + RegionStride + 32'h440, 32'hdead_0003, 4'hf);
    bus_access("above last", 1'b1, RegionBase + 3 * RegionStride + RegionBytes + 32'h40,
               32'hdead_0004, 4'hf);
    bus_access("gap read", 1'b0, RegionBase + 32'h8000, '0, 4'hf);
    for (int i = 0; i < NumRegions; i++) begin
      bus_access("region unchanged", 1'b0, RegionBase + i * RegionStride + 32'h40, '0, 4'hf);
    end

    // Random traffic
    for (int n = 0; n < NumRandom; n++) begin
      adr = rand_addr();
      r   = next_rand();
      bus_access($sformatf("random %0d", n), r[31], adr, next_rand(), r[27:24]);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    #(TimeoutNs);
    abort_run("Watchdog expired because the bus hung with no ack or err");
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+bench
verilog/spm_pkg.sv
verilog/wb_if.sv
verilog/wb_addr_decode.sv
verilog/spm_bank.sv
verilog/wb_resp_mux.sv
verilog/spm_subsystem.sv
bench/tb_spm_subsystem.sv

/* verilog/spm_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module spm_bank (
  input  wire  clk_i,
  input  wire  ndmreset_n,
  wb_if.slave  bus_i
);
  import spm_pkg::*;

  wb_data_t   mem [BankWords];
  wb_data_t   rdata_q;
  bank_addr_t word_idx;
  logic       access;
  logic       ack_q;

  // Decoder already reduced the address to a word index
  assign word_idx = bank_addr_t'(bus_i.adr);

  // No new access in the ack cycle
  assign access = bus_i.cyc & bus_i.stb & ~ack_q;

  // ----------------------------------------
  // Word memory
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (access && bus_i.we) begin
      for (int b = 0; b < SelWidth; b++) begin
        if (bus_i.sel[b]) begin
          mem[word_idx][8*b +: 8] <= bus_i.dat_w[8*b +: 8];
        end
      end
    end
  end

  // Read word, held until the next read
  always_ff @(posedge clk_i) begin
    if (access && !bus_i.we) begin
      rdata_q <= mem[word_idx];
    end
  end

  // ----------------------------------------
  // Acknowledge
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign bus_i.ack   = ack_q;
  assign bus_i.dat_r = rdata_q;
  // Every word of the bank exists, so no error response
  assign bus_i.err   = 1'b0;

  // Ack answers a strobe that the decoder routed here
  assert_ack_after_stb : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    bus_i.ack |-> $past(bus_i.cyc && bus_i.stb)
  );

  assert_err_low : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    !bus_i.err
  );

endmodule

`default_nettype wire

/* verilog/spm_pkg.sv */
`default_nettype none

package spm_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned SelWidth  = DataWidth / 8;
  // Byte offset bits below the word index
  localparam int unsigned WordLsb   = $clog2(SelWidth);

  // ----------------------------------------
  // Region map
  // ----------------------------------------
  localparam int unsigned          NumRegions   = 4;
  localparam logic [AddrWidth-1:0] RegionBase   = 32'h1000_0000;
  localparam logic [AddrWidth-1:0] RegionStride = 32'h0001_0000;
  // Much smaller than the stride, so gaps stay unmapped
  localparam int unsigned          RegionBytes  = 1024;

  localparam int unsigned BankWords     = RegionBytes / SelWidth;
  localparam int unsigned BankAddrWidth = $clog2(BankWords);

  // ----------------------------------------
  // Shared types
  // ----------------------------------------
  typedef logic [AddrWidth-1:0]     wb_addr_t;
  typedef logic [DataWidth-1:0]     wb_data_t;
  typedef logic [SelWidth-1:0]      wb_sel_t;
  typedef logic [NumRegions-1:0]    region_sel_t;
  typedef logic [BankAddrWidth-1:0] bank_addr_t;

  // Base address of one region
  function automatic wb_addr_t region_base(int unsigned idx);
    wb_addr_t step;
    step = RegionStride * idx;
    return RegionBase + step;
  endfunction

endpackage

`default_nettype wire

/* verilog/spm_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module spm_subsystem (
  input  wire                 clk_i,
  input  wire                 ndmreset_n,
  // Wishbone classic slave port
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  spm_pkg::wb_addr_t   wb_adr_i,
  input  spm_pkg::wb_data_t   wb_dat_i,
  input  spm_pkg::wb_sel_t    wb_sel_i,
  output spm_pkg::wb_data_t   wb_dat_o,
  output logic                wb_ack_o,
  output logic                wb_err_o
);
  import spm_pkg::*;

  logic dec_err;

  // One bus per scratchpad region
  wb_if bank_bus [NumRegions] ();

  // ----------------------------------------
  // Address decoder
  // ----------------------------------------
  wb_addr_decode i_addr_decode (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .cyc_i      ( wb_cyc_i   ),
    .stb_i      ( wb_stb_i   ),
    .we_i       ( wb_we_i    ),
    .adr_i      ( wb_adr_i   ),
    .dat_i      ( wb_dat_i   ),
    .sel_i      ( wb_sel_i   ),
    .err_o      ( dec_err    ),
    .bank_o     ( bank_bus   )
  );

  // ----------------------------------------
  // Scratchpad banks
  // ----------------------------------------
  for (genvar g = 0; g < NumRegions; g++) begin : gen_bank
    spm_bank i_bank (
      .clk_i      ( clk_i       ),
      .ndmreset_n ( ndmreset_n  ),
      .bus_i      ( bank_bus[g] )
    );
  end

  // ----------------------------------------
  // Response merge
  // ----------------------------------------
  wb_resp_mux i_resp_mux (
    .bank_i    ( bank_bus ),
    .dec_err_i ( dec_err  ),
    .dat_o     ( wb_dat_o ),
    .ack_o     ( wb_ack_o ),
    .err_o     ( wb_err_o )
  );

  // Every strobed request gets exactly one response one cycle later
  assert_resp_latency : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    (wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o) |=> (wb_ack_o || wb_err_o)
  );

endmodule

`default_nettype wire

/* verilog/wb_addr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_addr_decode (
  input  wire                 clk_i,
  input  wire                 ndmreset_n,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  spm_pkg::wb_addr_t   adr_i,
  input  spm_pkg::wb_data_t   dat_i,
  input  spm_pkg::wb_sel_t    sel_i,
  output logic                err_o,
  wb_if.master                bank_o [spm_pkg::NumRegions]
);
  import spm_pkg::*;

  region_sel_t region_sel;
  region_sel_t bank_stb;
  logic        req;
  logic        err_q;

  assign req = cyc_i & stb_i;

  // ----------------------------------------
  // Region match and bank request
  // ----------------------------------------
  for (genvar g = 0; g < NumRegions; g++) begin : gen_region
    wb_addr_t   offset;
    bank_addr_t word_idx;

    // Below the base wraps around to a large offset
    assign offset        = adr_i - region_base(g);
    assign region_sel[g] = (offset < RegionBytes);
    assign word_idx      = offset[WordLsb +: BankAddrWidth];

    assign bank_o[g].cyc   = cyc_i & region_sel[g];
    assign bank_o[g].stb   = bank_stb[g];
    assign bank_o[g].we    = we_i;
    assign bank_o[g].adr   = wb_addr_t'(word_idx);
    assign bank_o[g].dat_w = dat_i;
    assign bank_o[g].sel   = sel_i;
  end

  assign bank_stb = region_sel & {NumRegions{req}};

  // ----------------------------------------
  // Error for unmapped accesses
  // ----------------------------------------
  // One cycle high, then a quiet cycle while the master drops stb
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req & ~(|region_sel) & ~err_q;
    end
  end

  assign err_o = err_q;

  // Regions never overlap in the map
  assert_one_bank : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    $onehot0(bank_stb)
  );

endmodule

`default_nettype wire

/* verilog/wb_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface wb_if;
  import spm_pkg::*;

  // Request side
  logic     cyc;
  logic     stb;
  logic     we;
  wb_addr_t adr;
  wb_data_t dat_w;
  wb_sel_t  sel;

  // Response side
  wb_data_t dat_r;
  logic     ack;
  logic     err;

  // ----------------------------------------
  // Views
  // ----------------------------------------
  modport master (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack, err
  );

  // Response merger only listens
  modport monitor (
    input dat_r, ack, err
  );

endinterface

`default_nettype wire

/* verilog/wb_resp_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_resp_mux (
  wb_if.monitor               bank_i [spm_pkg::NumRegions],
  input  logic                dec_err_i,
  output spm_pkg::wb_data_t   dat_o,
  output logic                ack_o,
  output logic                err_o
);
  import spm_pkg::*;

  region_sel_t bank_ack;
  wb_data_t    bank_dat [NumRegions];

  // ----------------------------------------
  // Collect bank responses
  // ----------------------------------------
  for (genvar g = 0; g < NumRegions; g++) begin : gen_collect
    assign bank_ack[g] = bank_i[g].ack;
    assign bank_dat[g] = bank_i[g].dat_r;
  end

  // At most one bank acknowledges, so an AND-OR select is enough
  always_comb begin
    dat_o = '0;
    for (int i = 0; i < NumRegions; i++) begin
      dat_o = dat_o | (bank_dat[i] & {DataWidth{bank_ack[i]}});
    end
  end

  assign ack_o = |bank_ack;
  assign err_o = dec_err_i;

  // Decoder error and bank ack belong to different requests
  always_comb begin
    assert_ack_err_excl : assert #0 (!((ack_o === 1'b1) && (err_o === 1'b1)));
  end

endmodule

`default_nettype wire
